// ==== all.f ====
rtl/chol_pkg.sv
rtl/chol_ifs.sv
rtl/fix_sqrt.sv
rtl/fix_div_bank.sv
rtl/row_mac_bank.sv
rtl/chol_ctrl.sv
rtl/cholesky_top.sv
verification/cholesky_assert.sv
verification/tb_cholesky.sv

// ==== rtl/chol_ctrl.sv ====
`timescale 1ns/1ps

module chol_ctrl (
    input  logic                       clk,
    input  logic                       rst,
    input  chol_pkg::tri_t             a,
    input  logic                       a_valid,
    output chol_pkg::tri_t             l,
    output logic                       l_valid,
    sqrt_if.ctrl                       sq,
    div_if.ctrl                        dv,
    output logic                       red_start,
    output chol_pkg::col_t             red_col,
    output logic [chol_pkg::COL_W-1:0] red_diag_idx,
    input  logic                       red_done,
    input  chol_pkg::col_t             red_vals
);

    typedef enum logic [1:0] {
        IDLE,
        REDUCE,
        SQRT,
        DIVIDE
    } state_t;

    state_t                     state_q;
    chol_pkg::tri_t             a_q;          // Captured input triangle
    logic [chol_pkg::COL_W-1:0] j_q;          // Current column
    logic                       sq_start_q;
    logic                       dv_start_q;
    chol_pkg::elem_t            red_diag;     // Reduced value of row j

    assign red_diag_idx = j_q;
    assign red_diag     = red_vals[j_q];

    assign sq.start    = sq_start_q;
    assign sq.radicand = red_diag;
    assign dv.start    = dv_start_q;
    assign dv.divisor  = l[chol_pkg::tri_idx(int'(j_q), int'(j_q))];   // Fresh diagonal
    assign dv.dividend = red_vals;

    // Column j of the captured matrix, zero above the diagonal
    always_comb begin
        for (int i = 0; i < chol_pkg::N; i++) begin
            red_col[i] = (i >= int'(j_q)) ? a_q[chol_pkg::tri_idx(i, int'(j_q))] : '0;
        end
    end

    always_ff @(posedge clk) begin
        if (a_valid && state_q == IDLE) begin
            a_q <= a;
        end
    end

    // ============================
    // Phase sequencing
    // ============================
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q    <= IDLE;
            j_q        <= '0;
            red_start  <= 1'b0;
            sq_start_q <= 1'b0;
            dv_start_q <= 1'b0;
            l_valid    <= 1'b0;
            l          <= '0;
        end else begin
            red_start  <= 1'b0;
            sq_start_q <= 1'b0;
            dv_start_q <= 1'b0;
            l_valid    <= 1'b0;
            case (state_q)
                IDLE: begin
                    if (a_valid) begin
                        j_q       <= '0;
                        red_start <= 1'b1;
                        state_q   <= REDUCE;
                    end
                end
                REDUCE: begin
                    if (red_done) begin
                        sq_start_q <= 1'b1;             // Reduced values now stable
                        state_q    <= SQRT;
                    end
                end
                SQRT: begin
                    if (sq.done) begin
                        // Negative radicand gives a zero diagonal
                        l[chol_pkg::tri_idx(int'(j_q), int'(j_q))] <=
                            red_diag[chol_pkg::DATA_W-1] ? '0 : sq.root;
                        if (int'(j_q) == chol_pkg::N - 1) begin
                            l_valid <= 1'b1;            // Last column has no divide
                            state_q <= IDLE;
                        end else begin
                            dv_start_q <= 1'b1;
                            state_q    <= DIVIDE;
                        end
                    end
                end
                DIVIDE: begin
                    if (dv.done) begin
                        for (int i = 1; i < chol_pkg::N; i++) begin
                            if (i > int'(j_q)) begin
                                l[chol_pkg::tri_idx(i, int'(j_q))] <= dv.quotient[i];
                            end
                        end
                        j_q       <= j_q + 1'b1;
                        red_start <= 1'b1;
                        state_q   <= REDUCE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

endmodule

// ==== rtl/chol_ifs.sv ====
`timescale 1ns/1ps

// Square root unit handshake
interface sqrt_if;
    logic            start;
    chol_pkg::elem_t radicand;
    chol_pkg::elem_t root;
    logic            done;

    modport ctrl (
        output start,
        output radicand,
        input  root,
        input  done
    );

    modport unit (
        input  start,
        input  radicand,
        output root,
        output done
    );
endinterface

// Divider bank handshake, all lanes share the divisor
interface div_if;
    logic            start;
    chol_pkg::elem_t divisor;
    chol_pkg::col_t  dividend;
    chol_pkg::col_t  quotient;
    logic            done;

    modport ctrl (
        output start,
        output divisor,
        output dividend,
        input  quotient,
        input  done
    );

    modport unit (
        input  start,
        input  divisor,
        input  dividend,
        output quotient,
        output done
    );
endinterface

// ==== rtl/chol_pkg.sv ====
package chol_pkg;

    // ============================
    // Sizes
    // ============================
    localparam int N         = 5;                  // Matrix order
    localparam int NUM_ELEMS = N * (N + 1) / 2;    // Lower triangle size
    localparam int DATA_W    = 32;
    localparam int FRAC_W    = 16;                 // Q16.16
    localparam int ACC_W     = 64;                 // Q32.32 product sums
    localparam int COL_W     = 3;                  // Row or column index

    // Iteration counts of the arithmetic units
    localparam int SQRT_ITER = 24;                 // Root bits
    localparam int DIV_ITER  = 48;                 // Quotient bits

    // ============================
    // Types
    // ============================
    typedef logic signed [DATA_W-1:0] elem_t;
    typedef logic signed [ACC_W-1:0]  acc_t;
    typedef elem_t [NUM_ELEMS-1:0]    tri_t;       // Element 0 in the low bits
    typedef elem_t [N-1:0]            col_t;       // One value per row

    // Position of element (i,j) with i >= j in the packed triangle
    function automatic int tri_idx(input int i, input int j);
        return i * (i + 1) / 2 + j;
    endfunction

endpackage

// ==== rtl/cholesky_top.sv ====
`timescale 1ns/1ps

module cholesky_top (
    input  logic           clk,
    input  logic           rst,
    input  chol_pkg::tri_t a,
    input  logic           a_valid,
    output chol_pkg::tri_t l,
    output logic           l_valid
);

    sqrt_if sq ();
    div_if  dv ();

    logic                       red_start;
    logic                       red_done;
    logic [chol_pkg::COL_W-1:0] red_diag_idx;
    chol_pkg::col_t             red_col;
    chol_pkg::col_t             red_vals;

    chol_ctrl i_chol_ctrl (
        .clk          (clk),
        .rst          (rst),
        .a            (a),
        .a_valid      (a_valid),
        .l            (l),
        .l_valid      (l_valid),
        .sq           (sq.ctrl),
        .dv           (dv.ctrl),
        .red_start    (red_start),
        .red_col      (red_col),
        .red_diag_idx (red_diag_idx),
        .red_done     (red_done),
        .red_vals     (red_vals)
    );

    fix_sqrt i_fix_sqrt (
        .clk (clk),
        .rst (rst),
        .sq  (sq.unit)
    );

    fix_div_bank i_fix_div_bank (
        .clk (clk),
        .rst (rst),
        .dv  (dv.unit)
    );

    // Reads the factor columns written so far
    row_mac_bank i_row_mac_bank (
        .clk          (clk),
        .rst          (rst),
        .red_start    (red_start),
        .red_diag_idx (red_diag_idx),
        .red_col      (red_col),
        .l            (l),
        .red_done     (red_done),
        .red_vals     (red_vals)
    );

endmodule

// ==== rtl/fix_div_bank.sv ====
`timescale 1ns/1ps

module fix_div_bank (
    input logic clk,
    input logic rst,
    div_if.unit dv
);

    typedef logic [$clog2(chol_pkg::DIV_ITER + 1)-1:0] cnt_t;

    logic [chol_pkg::DATA_W-1:0] dmag;
    logic [chol_pkg::DATA_W-1:0] dmag_q;     // Shared divisor magnitude
    logic                        dneg_q;
    logic                        dzero_q;
    cnt_t                        cnt_q;
    logic                        busy_q;
    logic                        done_q;
    chol_pkg::col_t              quot;

    assign dmag = dv.divisor[chol_pkg::DATA_W-1] ? -dv.divisor : dv.divisor;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (dv.start) begin
                busy_q <= 1'b1;
                cnt_q  <= '0;
            end else if (busy_q) begin
                cnt_q <= cnt_q + 1'b1;
                if (cnt_q == cnt_t'(chol_pkg::DIV_ITER - 1)) begin
                    busy_q <= 1'b0;
                    done_q <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dv.start) begin
            dmag_q  <= dmag;
            dneg_q  <= dv.divisor[chol_pkg::DATA_W-1];
            dzero_q <= (dv.divisor == '0);
        end
    end

    assign quot[0] = '0;                     // Row 0 is never below a diagonal

    // ============================
    // Lanes in lockstep
    // ============================
    for (genvar g = 1; g < chol_pkg::N; g++) begin : g_lane
        logic [chol_pkg::DATA_W-1:0]                  nmag;
        logic [chol_pkg::DATA_W+chol_pkg::FRAC_W-1:0] nq_q;   // Numerator in, quotient out
        logic [chol_pkg::DATA_W-1:0]                  rem_q;
        logic                                         nneg_q;
        logic [chol_pkg::DATA_W:0]                    cand;
        logic [chol_pkg::DATA_W:0]                    diff;
        logic [chol_pkg::DATA_W-1:0]                  qlow;

        assign nmag = dv.dividend[g][chol_pkg::DATA_W-1] ? -dv.dividend[g] : dv.dividend[g];
        assign cand = {rem_q, nq_q[chol_pkg::DATA_W+chol_pkg::FRAC_W-1]};
        assign diff = cand - {1'b0, dmag_q};
        assign qlow = nq_q[chol_pkg::DATA_W-1:0];

        always_ff @(posedge clk) begin
            if (dv.start) begin
                nq_q   <= {nmag, {chol_pkg::FRAC_W{1'b0}}};
                rem_q  <= '0;
                nneg_q <= dv.dividend[g][chol_pkg::DATA_W-1];
            end else if (busy_q) begin
                if (cand >= {1'b0, dmag_q}) begin
                    rem_q <= diff[chol_pkg::DATA_W-1:0];
                    nq_q  <= {nq_q[chol_pkg::DATA_W+chol_pkg::FRAC_W-2:0], 1'b1};
                end else begin
                    rem_q <= cand[chol_pkg::DATA_W-1:0];
                    nq_q  <= {nq_q[chol_pkg::DATA_W+chol_pkg::FRAC_W-2:0], 1'b0};
                end
            end
        end

        // Magnitude division already truncates toward zero
        assign quot[g] = dzero_q           ? '1 :
                         (nneg_q ^ dneg_q) ? chol_pkg::elem_t'(-qlow) :
                                             chol_pkg::elem_t'(qlow);
    end

    assign dv.quotient = quot;
    assign dv.done     = done_q;

endmodule

// ==== rtl/fix_sqrt.sv ====
`timescale 1ns/1ps

module fix_sqrt (
    input logic  clk,
    input logic  rst,
    sqrt_if.unit sq
);

    typedef logic [$clog2(chol_pkg::SQRT_ITER + 1)-1:0] cnt_t;

    logic [chol_pkg::DATA_W+chol_pkg::FRAC_W-1:0] op_q;   // Radicand bits still to consume
    logic [chol_pkg::SQRT_ITER+1:0]               rem_q;
    logic [chol_pkg::SQRT_ITER-1:0]               root_q;
    logic [chol_pkg::SQRT_ITER+3:0]               cand;
    logic [chol_pkg::SQRT_ITER+3:0]               trial;
    logic [chol_pkg::SQRT_ITER+3:0]               diff;
    cnt_t                                         cnt_q;
    logic                                         busy_q;
    logic                                         done_q;

    // Bring down two radicand bits and try 4*root + 1
    assign cand  = {rem_q, op_q[chol_pkg::DATA_W+chol_pkg::FRAC_W-1 -: 2]};
    assign trial = {2'b00, root_q, 2'b01};
    assign diff  = cand - trial;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (sq.start) begin
                busy_q <= 1'b1;
                cnt_q  <= '0;
            end else if (busy_q) begin
                cnt_q <= cnt_q + 1'b1;
                if (cnt_q == cnt_t'(chol_pkg::SQRT_ITER - 1)) begin
                    busy_q <= 1'b0;
                    done_q <= 1'b1;                       // Last root bit lands now
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (sq.start) begin
            op_q   <= {sq.radicand, {chol_pkg::FRAC_W{1'b0}}};   // Root comes out in Q16.16
            rem_q  <= '0;
            root_q <= '0;
        end else if (busy_q) begin
            op_q <= op_q << 2;
            if (cand >= trial) begin
                rem_q  <= diff[chol_pkg::SQRT_ITER+1:0];
                root_q <= {root_q[chol_pkg::SQRT_ITER-2:0], 1'b1};
            end else begin
                rem_q  <= cand[chol_pkg::SQRT_ITER+1:0];
                root_q <= {root_q[chol_pkg::SQRT_ITER-2:0], 1'b0};
            end
        end
    end

    assign sq.root = chol_pkg::elem_t'(root_q);          // Zero extended
    assign sq.done = done_q;

endmodule

// ==== rtl/row_mac_bank.sv ====
`timescale 1ns/1ps

module row_mac_bank (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       red_start,
    input  logic [chol_pkg::COL_W-1:0] red_diag_idx,
    input  chol_pkg::col_t             red_col,
    input  chol_pkg::tri_t             l,
    output logic                       red_done,
    output chol_pkg::col_t             red_vals
);

    logic [chol_pkg::COL_W-1:0] j_q;        // Column being reduced
    logic [chol_pkg::COL_W-1:0] k_q;        // Earlier column used this cycle
    logic                       busy_q;
    chol_pkg::elem_t            l_jk;

    assign l_jk = l[chol_pkg::tri_idx(int'(j_q), int'(k_q))];   // Shared by all rows

    always_ff @(posedge clk) begin
        if (rst) begin
            j_q      <= '0;
            k_q      <= '0;
            busy_q   <= 1'b0;
            red_done <= 1'b0;
        end else begin
            red_done <= 1'b0;
            if (red_start) begin
                j_q      <= red_diag_idx;
                k_q      <= '0;
                busy_q   <= (red_diag_idx != '0);
                red_done <= (red_diag_idx == '0);   // Nothing to sum in column 0
            end else if (busy_q) begin
                k_q <= k_q + 1'b1;
                if (k_q + 1'b1 == j_q) begin
                    busy_q   <= 1'b0;
                    red_done <= 1'b1;
                end
            end
        end
    end

    // ============================
    // One accumulator per row
    // ============================
    for (genvar i = 0; i < chol_pkg::N; i++) begin : g_row
        chol_pkg::elem_t l_ik;
        chol_pkg::acc_t  acc_q;

        // Rows above j run too and their results go unused
        assign l_ik = l[chol_pkg::tri_idx(i, int'(k_q))];

        always_ff @(posedge clk) begin
            if (red_start) begin
                acc_q <= '0;
            end else if (busy_q) begin
                acc_q <= acc_q + chol_pkg::acc_t'(l_ik) * chol_pkg::acc_t'(l_jk);
            end
        end

        // Back to Q16.16 before the subtraction
        assign red_vals[i] = red_col[i] - chol_pkg::elem_t'(acc_q >>> chol_pkg::FRAC_W);
    end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the Cholesky testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing --assert --top-module tb_cholesky -f all.f \
    -o sim_cholesky > build.log 2>&1 \
    && ./obj_dir/sim_cholesky > sim.log 2>&1 \
    || echo "build or simulation ended with an error, see build.log and sim.log"

grep -qx "Everything OK" sim.log \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

// ==== verification/cholesky_assert.sv ====
`timescale 1ns/1ps

module cholesky_assert (
    input logic clk,
    input logic rst,
    input logic l_valid,
    input logic sq_start,
    input logic sq_done,
    input logic dv_start,
    input logic dv_done
);

    logic sq_busy;
    logic dv_busy;
    int   fail_cnt = 0;                                        // Failed assertions so far

    always_ff @(posedge clk) begin
        if (rst) begin
            sq_busy <= 1'b0;
            dv_busy <= 1'b0;
        end else begin
            if (sq_start) begin
                sq_busy <= 1'b1;
            end else if (sq_done) begin
                sq_busy <= 1'b0;
            end
            if (dv_start) begin
                dv_busy <= 1'b1;
            end else if (dv_done) begin
                dv_busy <= 1'b0;
            end
        end
    end

    a_l_valid_pulse: assert property (@(posedge clk) disable iff (rst) l_valid |=> !l_valid)
        else begin
            fail_cnt++;
            $error("l_valid high on two cycles in a row");
        end

    // Start only when idle, done only after a start
    a_sqrt_seq: assert property (@(posedge clk) disable iff (rst)
        !(sq_start && sq_busy) && !(sq_done && !sq_busy))
        else begin
            fail_cnt++;
            $error("square root start or done out of order");
        end

    a_div_seq: assert property (@(posedge clk) disable iff (rst)
        !(dv_start && dv_busy) && !(dv_done && !dv_busy))
        else begin
            fail_cnt++;
            $error("divider start or done out of order");
        end

endmodule

bind cholesky_top cholesky_assert i_cholesky_assert (
    .clk      (clk),
    .rst      (rst),
    .l_valid  (l_valid),
    .sq_start (sq.start),
    .sq_done  (sq.done),
    .dv_start (dv.start),
    .dv_done  (dv.done)
);

// ==== verification/tb_cholesky.sv ====
`timescale 1ns/1ps

module tb_cholesky;

    localparam int NUM_RANDOM  = 40;
    localparam int NUM_RUNS    = NUM_RANDOM + 2;               // Plus busy and diagonal runs
    localparam int RUN_BOUND   = chol_pkg::N *
        (chol_pkg::N + chol_pkg::SQRT_ITER + chol_pkg::DIV_ITER + 6);
    localparam int CYCLE_LIMIT = NUM_RUNS * RUN_BOUND + 100;

    logic           clk = 1'b0;
    logic           rst;
    logic           a_valid;
    chol_pkg::tri_t a;
    chol_pkg::tri_t l;
    logic           l_valid;
    logic [31:0]    lfsr;
    int             cycles   = 0;
    int             pulses   = 0;                              // l_valid pulses seen
    int             accepted = 0;

    cholesky_top i_cholesky_top (
        .clk     (clk),
        .rst     (rst),
        .a       (a),
        .a_valid (a_valid),
        .l       (l),
        .l_valid (l_valid)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: no result after %0d cycles", cycles);
            $display("Something failed");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    always @(negedge clk) begin
        if (l_valid) begin
            pulses <= pulses + 1;
        end
    end

    // ==============================
    // Stimulus and reference model
    // ==============================
    function automatic int tri_pos(input int i, input int j);
        return i * (i + 1) / 2 + j;
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int b = 0; b < n; b++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);   // Galois step
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic chol_pkg::elem_t abs_val(input chol_pkg::elem_t x);
        return (x < 0) ? -x : x;
    endfunction

    function automatic logic [31:0] floor_sqrt(input logic [63:0] x);
        logic [63:0] r;
        logic [63:0] t;
        r = '0;
        for (int b = chol_pkg::SQRT_ITER - 1; b >= 0; b--) begin
            t = r | (64'd1 << b);
            if (t * t <= x) begin
                r = t;
            end
        end
        return r[31:0];
    endfunction

    // Diagonally dominant, so symmetric positive definite
    task automatic make_spd(input bit diag_only, output chol_pkg::tri_t m);
        logic [31:0]     r;
        chol_pkg::elem_t row_sum;
        m = '0;
        for (int i = 1; i < chol_pkg::N; i++) begin
            for (int j = 0; j < i; j++) begin
                r = take_bits(18);                             // [-2, 2) in Q16.16
                m[tri_pos(i, j)] = diag_only ? '0 : chol_pkg::elem_t'({{14{r[17]}}, r[17:0]});
            end
        end
        for (int i = 0; i < chol_pkg::N; i++) begin
            row_sum = 32'sh0001_0000;
            for (int k = 0; k < chol_pkg::N; k++) begin
                if (k < i) begin
                    row_sum = row_sum + abs_val(m[tri_pos(i, k)]);
                end else if (k > i) begin
                    row_sum = row_sum + abs_val(m[tri_pos(k, i)]);
                end
            end
            r = take_bits(18);                                 // Up to 4.0 extra
            m[tri_pos(i, i)] = row_sum + chol_pkg::elem_t'(r);
        end
    endtask

    function automatic chol_pkg::tri_t model_factor(input chol_pkg::tri_t m);
        chol_pkg::tri_t  f;
        chol_pkg::elem_t red [chol_pkg::N];
        chol_pkg::elem_t li;
        chol_pkg::elem_t lj;
        chol_pkg::acc_t  sum;
        logic [31:0]     mag;
        logic [63:0]     den;
        logic [63:0]     q;
        f = '0;
        for (int j = 0; j < chol_pkg::N; j++) begin
            for (int i = j; i < chol_pkg::N; i++) begin
                sum = '0;
                for (int k = 0; k < j; k++) begin
                    li  = f[tri_pos(i, k)];
                    lj  = f[tri_pos(j, k)];
                    sum = sum + chol_pkg::acc_t'(li) * chol_pkg::acc_t'(lj);
                end
                red[i] = m[tri_pos(i, j)] - chol_pkg::elem_t'(sum >>> chol_pkg::FRAC_W);
            end
            f[tri_pos(j, j)] = red[j][31] ? '0 : floor_sqrt({16'b0, red[j], 16'b0});
            den = {32'b0, f[tri_pos(j, j)]};
            for (int i = j + 1; i < chol_pkg::N; i++) begin
                mag = red[i][31] ? -red[i] : red[i];
                if (den == '0) begin
                    f[tri_pos(i, j)] = '1;
                end else begin
                    q = {16'b0, mag, 16'b0} / den;             // Truncates toward zero
                    f[tri_pos(i, j)] = red[i][31] ? -q[31:0] : q[31:0];
                end
            end
        end
        return f;
    endfunction

    // ==============================
    // Checks and runs
    // ==============================
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("mismatch %s got %h expected %h", name, got, expected);
            $display("Something failed");
            $fatal(1, "stopped at the first wrong value");
        end
    endtask

    task automatic run_matrix(input chol_pkg::tri_t m, input bit poke_busy);
        chol_pkg::tri_t expected;
        chol_pkg::tri_t other;
        expected = model_factor(m);
        @(posedge clk);
        check_value("l_valid pulses", pulses, accepted);
        a       <= m;
        a_valid <= 1'b1;
        @(posedge clk);
        a_valid  <= 1'b0;
        accepted  = accepted + 1;
        if (poke_busy) begin
            make_spd(1'b0, other);
            repeat (3) @(posedge clk);
            a       <= other;                                  // Engine busy, must be ignored
            a_valid <= 1'b1;
            @(posedge clk);
            a_valid <= 1'b0;
        end
        @(negedge clk);
        while (!l_valid) @(negedge clk);
        for (int e = 0; e < chol_pkg::NUM_ELEMS; e++) begin
            check_value($sformatf("l[%0d]", e), l[e], expected[e]);
        end
    endtask

    initial begin
        chol_pkg::tri_t m;
        rst     = 1'b1;
        a       = '0;
        a_valid = 1'b0;
        lfsr    = 32'he53b_948e;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        repeat (5) begin                                       // Quiet until the first matrix
            @(negedge clk);
            check_value("l_valid", l_valid, 1'b0);
            for (int e = 0; e < chol_pkg::NUM_ELEMS; e++) begin
                check_value($sformatf("l[%0d]", e), l[e], '0);
            end
        end
        for (int n = 0; n < NUM_RANDOM; n++) begin
            make_spd(1'b0, m);
            run_matrix(m, 1'b0);
        end
        make_spd(1'b0, m);
        run_matrix(m, 1'b1);
        make_spd(1'b1, m);
        run_matrix(m, 1'b0);
        repeat (4) @(negedge clk);
        check_value("l_valid pulses", pulses, accepted);
        if (i_cholesky_top.i_cholesky_assert.fail_cnt != 0) begin
            $display("Something failed");
            $fatal(1, "assertion failures were recorded");
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule
